//--- verilog.f
+incdir+include
verilog/nimplus_pkg.sv
verilog/register_map.sv
verilog/output_router.sv
verilog/clock_rate_monitor.sv
verilog/nimplus_top.sv
test/nimplus_assertions.sv
test/nimplus_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the NIM+ core testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
   -f verilog.f --top-module nimplus_tb -o nimplus_sim

# Let the run reach its closing line even after failed assertions
./obj_dir/nimplus_sim +verilator+error+limit+100000 > sim.log 2>&1 || true
cat sim.log

if grep -qx "Done: no errors" sim.log; then
   exit 0
else
   exit 1
fi

//--- test/nimplus_tb.sv
`include "nimplus_defines.svh"

module nimplus_tb
   import nimplus_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD    = 4;                    // ns
   localparam int RANDOM_CYCLES = 1500;
   localparam int TEST_CYCLES   = 2500;                 // All phases, rounded up
   localparam int WATCHDOG_NS   = 2 * TEST_CYCLES * CLK_PERIOD;
   localparam int ACK_WAIT      = 4;                    // Cycles allowed for an ack
   localparam int TEST_WINDOW   = 200;

   logic                      clk_160 = 1'b0;
   logic                      reset;
   bus_req_t                  bus_req;
   bus_rsp_t                  bus_rsp;
   route_src_t                src;
   logic [`NUM_TEST_CLKS-1:0] test_clk = '0;
   route_dst_t                dst;
   int                        toggle_cnt [`NUM_TEST_CLKS] = '{default: 0};
   logic [31:0]               lfsr_state = 32'h126b5c71;
   int                        handshake_errors = 0;

   nimplus_top i_dut
   (
      .clk_160  (clk_160),
      .reset    (reset),
      .bus_req  (bus_req),
      .bus_rsp  (bus_rsp),
      .src      (src),
      .test_clk (test_clk),
      .dst      (dst)
   );

   always #(CLK_PERIOD / 2) clk_160 = ~clk_160;

   // Test clock k toggles every k+2 cycles
   always @(posedge clk_160)
   begin
      for (int k = 0; k < `NUM_TEST_CLKS; k++)
      begin
         if (toggle_cnt[k] == k + 1)
         begin
            toggle_cnt[k] <= 0;
            test_clk[k]   <= ~test_clk[k];
         end
         else
         begin
            toggle_cnt[k] <= toggle_cnt[k] + 1;
         end
      end
   end

   // Galois LFSR, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // One LFSR step per bit
   function automatic logic [63:0] take_bits(input int n);
      logic [63:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         v[i]       = lfsr_state[0];
      end
      return v;
   endfunction

   // Random mux word, selection mostly in range
   function automatic logic [63:0] mux_word();
      logic [63:0] w;
      w = take_bits(64);
      if (take_bits(2) != 0)
      begin
         w[`SEL_W-1:0] = `SEL_W'(take_bits(5));  // 30 and 31 still out of range
      end
      return w;
   endfunction

   // Drives one bus cycle on the next rising edge
   task automatic issue(input logic wr, input logic rd, input logic [`ADDR_W-1:0] index,
                        input logic [`REG_W-1:0] word);
      @(posedge clk_160);
      bus_req <= '{wren: wr, rden: rd, addr: index, data: word};
   endtask

   // Drops the strobe and waits for the ack of the last access
   task automatic finish_access(input logic is_read);
      logic seen;
      seen = 1'b0;
      issue(1'b0, 1'b0, '0, '0);
      for (int i = 0; i < ACK_WAIT && !seen; i++)
      begin
         @(posedge clk_160);
         seen = is_read ? bus_rsp.rdack : bus_rsp.wrack;
      end
      if (!seen)
      begin
         $display("Bus acknowledge missing at %0t after the last strobe", $time);
         handshake_errors++;
      end
   endtask

   // Reads on consecutive cycles
   task automatic read_burst(input int first, input int last);
      for (int a = first; a <= last; a++)
      begin
         issue(1'b0, 1'b1, `ADDR_W'(a), '0);
      end
      finish_access(1'b1);
   endtask

   initial
   begin
      logic [2:0]              pick;
      logic [`ADDR_W-1:0]      idx;
      logic [`NUM_SOURCES-1:0] src_bits;
      reset   = 1'b1;
      bus_req = '0;
      src     = '0;
      repeat (2) @(posedge clk_160);
      reset <= 1'b0;
      read_burst(0, 40);                                   // Reset values
      for (int a = 0; a < `NUM_REGS; a++)
      begin
         issue(1'b1, 1'b0, `ADDR_W'(a),
               a == `REG_WINDOW ? 64'hffff_0000_0000_0280 : take_bits(64));
      end
      issue(1'b1, 1'b0, 8'd36, take_bits(64));           // Unmapped writes
      issue(1'b1, 1'b0, 8'd255, take_bits(64));
      finish_access(1'b0);
      read_burst(0, 40);
      read_burst(255, 255);
      for (int c = 0; c < RANDOM_CYCLES; c++)
      begin
         pick = 3'(take_bits(3));
         idx  = `ADDR_W'(take_bits(5));
         if (pick == 0 && idx < `NUM_ROUTES)
         begin
            issue(1'b1, 1'b0, idx, mux_word());
         end
         else if (pick == 1)
         begin
            issue(1'b0, 1'b1, idx, '0);                    // Counts are read here too
         end
         else
         begin
            issue(1'b0, 1'b0, '0, '0);
         end
         src_bits = `NUM_SOURCES'(take_bits(`NUM_SOURCES));
         src     <= src_bits;
      end
      issue(1'b0, 1'b0, '0, '0);
      issue(1'b1, 1'b0, `ADDR_W'(`REG_WINDOW), 64'(TEST_WINDOW));
      finish_access(1'b0);
      repeat (2 * TEST_WINDOW + 20) @(posedge clk_160);  // Two full windows
      read_burst(`REG_COUNT_BASE, `NUM_REGS - 1);
      issue(1'b1, 1'b0, `ADDR_W'(`REG_COUNT_BASE), '1);  // Count registers are read only
      issue(1'b1, 1'b0, `ADDR_W'(`REG_COUNT_BASE + 2), '1);
      finish_access(1'b0);
      read_burst(`REG_WINDOW, `NUM_REGS - 1);
      repeat (TEST_WINDOW) @(posedge clk_160);
      read_burst(`REG_COUNT_BASE, `NUM_REGS - 1);
      repeat (4) @(posedge clk_160);
      $display("Errors: %0d from assertions, %0d from bus handshakes",
               i_dut.u_assertions.error_count, handshake_errors);
      if (i_dut.u_assertions.error_count + handshake_errors == 0)
      begin
         $display("Done: no errors");
      end
      else
      begin
         $display("Done: errors found");
      end
      $finish;
   end

   // Watchdog at twice the expected run length
   initial
   begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
      $display("Done: errors found");
      $finish;
   end

endmodule

//--- test/nimplus_assertions.sv
`include "nimplus_defines.svh"

module nimplus_assertions
   import nimplus_pkg::*;
(
   input logic       clk_160,
   input logic       reset,
   input bus_req_t   bus_req,
   input bus_rsp_t   bus_rsp,
   input route_src_t src,
   input route_dst_t dst
);

   timeunit 1ns;
   timeprecision 1ps;

   localparam logic [`ADDR_W-1:0] ROUTE_END = `ADDR_W'(`NUM_ROUTES);
   localparam logic [`ADDR_W-1:0] WIN_ADDR  = `ADDR_W'(`REG_WINDOW);
   localparam logic [`ADDR_W-1:0] CNT_BASE  = `ADDR_W'(`REG_COUNT_BASE);
   localparam logic [`ADDR_W-1:0] REG_END   = `ADDR_W'(`NUM_REGS);

   int                      error_count = 0;            // Failed assertions so far
   logic [`SEL_W-1:0]       shadow_sel [`NUM_ROUTES];   // Selections seen on the bus
   logic                    shadow_inv [`NUM_ROUTES];   // Invert bits seen on the bus
   logic [`COUNT_W-1:0]     shadow_win;
   logic [31:0]             win_age;                    // Cycles since the last window write
   logic [`NUM_SOURCES-1:0] flat_src;
   logic [`NUM_ROUTES-1:0]  exp_dst;                    // Expected next dst, route order
   logic [`NUM_ROUTES-1:0]  got_dst;
   logic [`REG_W-1:0]       exp_rd;                     // Expected data for this read index
   logic                    is_count;
   int                      clk_idx;                    // Test clock of a count index
   logic [`REG_W-1:0]       exp_rd_q;
   logic [`REG_W-1:0]       cnt_exp_q;                  // Nominal edges per window
   logic                    exact_q;                    // Pending read has a known value
   logic                    cnt_chk_q;                  // Pending count read is settled

   // Shadow copy of the writable registers
   always_ff @(posedge clk_160)
   begin
      if (reset)
      begin
         for (int r = 0; r < `NUM_ROUTES; r++)
         begin
            shadow_sel[r] <= '0;
            shadow_inv[r] <= 1'b0;
         end
         shadow_win <= `DEFAULT_WINDOW;
         win_age    <= '0;
      end
      else
      begin
         win_age <= (win_age == '1) ? win_age : win_age + 1;  // Saturates
         if (bus_req.wren && bus_req.addr < ROUTE_END)
         begin
            shadow_sel[bus_req.addr[4:0]] <= bus_req.data[`SEL_W-1:0];
            shadow_inv[bus_req.addr[4:0]] <= bus_req.data[`SEL_W];
         end
         else if (bus_req.wren && bus_req.addr == WIN_ADDR)
         begin
            shadow_win <= bus_req.data[`COUNT_W-1:0];  // Padding above is dropped
            win_age    <= '0;
         end
      end
   end

   // Expected crossbar output and read data
   always_comb
   begin
      flat_src = {src.sma_in, src.rj45_in_2, src.rj45_in_1, src.lvds_in, src.nim_in};
      for (int r = 0; r < `NUM_ROUTES; r++)
      begin
         exp_dst[r] = (shadow_sel[r] < `NUM_SOURCES ? flat_src[shadow_sel[r][4:0]] : 1'b0)
                      ^ (r < 4 && shadow_inv[r]);     // Only NIM outputs invert
      end
      got_dst  = {dst.sma_out, dst.rj45_out_2, dst.rj45_out_1, dst.nim_out};
      is_count = bus_req.addr >= CNT_BASE && bus_req.addr < REG_END;
      clk_idx  = is_count ? int'(bus_req.addr) - `REG_COUNT_BASE : 0;
      exp_rd   = '0;                                  // Unmapped reads give zero
      if (bus_req.addr < ROUTE_END)
      begin
         exp_rd = `REG_W'({shadow_inv[bus_req.addr[4:0]], shadow_sel[bus_req.addr[4:0]]});
      end
      else if (bus_req.addr == WIN_ADDR)
      begin
         exp_rd = `REG_W'(shadow_win);
      end
   end

   // Expectation for each read, held until its rdack
   always_ff @(posedge clk_160)
   begin
      if (reset)
      begin
         exact_q   <= 1'b0;
         cnt_chk_q <= 1'b0;
      end
      else if (bus_req.rden)
      begin
         exact_q   <= !is_count;
         cnt_chk_q <= is_count && 64'(win_age) >= 2 * 64'(shadow_win) + 8;  // Full window seen
         exp_rd_q  <= exp_rd;
         cnt_exp_q <= 64'(shadow_win) / 64'(2 * (clk_idx + 2));  // Clock k has period 2(k+2)
      end
   end

   wrack_follows_wren: assert property (@(posedge clk_160) disable iff (reset)
      bus_rsp.wrack == $past(bus_req.wren))
   else
   begin
      $error("ERR %0t: wrack does not match a wren one cycle earlier", $time);
      error_count = error_count + 1;
   end

   rdack_follows_rden: assert property (@(posedge clk_160) disable iff (reset)
      bus_rsp.rdack == $past(bus_req.rden))
   else
   begin
      $error("ERR %0t: rdack does not match an rden one cycle earlier", $time);
      error_count = error_count + 1;
   end

   read_data_matches: assert property (@(posedge clk_160) disable iff (reset)
      bus_rsp.rdack && exact_q |-> bus_rsp.data == exp_rd_q)
   else
   begin
      $error("ERR %0t: read data %h, expected %h", $time, bus_rsp.data, exp_rd_q);
      error_count = error_count + 1;
   end

   count_in_range: assert property (@(posedge clk_160) disable iff (reset)
      bus_rsp.rdack && cnt_chk_q |->
         bus_rsp.data + 1 >= cnt_exp_q && bus_rsp.data <= cnt_exp_q + 1)
   else
   begin
      $error("ERR %0t: count %0d, expected %0d within one", $time, bus_rsp.data, cnt_exp_q);
      error_count = error_count + 1;
   end

   dst_follows_route: assert property (@(posedge clk_160) disable iff (reset)
      got_dst == $past(exp_dst))
   else
   begin
      $error("ERR %0t: dst %h, expected %h", $time, got_dst, $past(exp_dst));
      error_count = error_count + 1;
   end

endmodule

bind nimplus_top nimplus_assertions u_assertions
(
   .clk_160 (clk_160),
   .reset   (reset),
   .bus_req (bus_req),
   .bus_rsp (bus_rsp),
   .src     (src),
   .dst     (dst)
);

//--- verilog/nimplus_top.sv
`include "nimplus_defines.svh"

module nimplus_top
   import nimplus_pkg::*;
(
   input  logic                      clk_160,   // System clock, single domain
   input  logic                      reset,     // Synchronous, active high
   input  bus_req_t                  bus_req,   // Register bus from Ethernet side
   output bus_rsp_t                  bus_rsp,
   input  route_src_t                src,       // NIM, LVDS, RJ45 and SMA inputs
   input  logic [`NUM_TEST_CLKS-1:0] test_clk,  // Clocks under measurement
   output route_dst_t                dst        // NIM, RJ45 and SMA outputs
);

   route_cfg_t          route_cfg;  // Mux settings
   logic [`COUNT_W-1:0] window;     // Monitor window length
   clk_counts_t         counts;     // Measured edge counts

   // Settings storage and bus readback
   register_map u_register_map
   (
      .clk_160   (clk_160),
      .reset     (reset),
      .bus_req   (bus_req),
      .bus_rsp   (bus_rsp),
      .counts    (counts),
      .route_cfg (route_cfg),
      .window    (window)
   );

   // Front panel crossbar
   output_router u_output_router
   (
      .clk_160   (clk_160),
      .reset     (reset),
      .src       (src),
      .route_cfg (route_cfg),
      .dst       (dst)
   );

   // Test clock rate counters
   clock_rate_monitor u_clock_rate_monitor
   (
      .clk_160   (clk_160),
      .reset     (reset),
      .test_clk  (test_clk),
      .window    (window),
      .counts    (counts)
   );

endmodule

//--- verilog/clock_rate_monitor.sv
`include "nimplus_defines.svh"

module clock_rate_monitor
   import nimplus_pkg::*;
(
   input  logic                      clk_160,
   input  logic                      reset,
   input  logic [`NUM_TEST_CLKS-1:0] test_clk,  // Sampled, not used as clocks
   input  logic [`COUNT_W-1:0]       window,    // Window length in cycles
   output clk_counts_t               counts     // Edges in the last full window
);

   localparam int N  = `NUM_TEST_CLKS;
   localparam int CW = `COUNT_W;

   logic [N-1:0]  sync_a;      // First synchronizer stage
   logic [N-1:0]  sync_b;      // Second synchronizer stage
   logic [N-1:0]  sync_prev;   // Previous synchronized level
   logic [N-1:0]  rise;        // Rising edge seen this cycle
   logic [CW-1:0] cnt [N];     // Running edge counters
   logic [CW-1:0] timer;       // Shared window timer
   logic [CW-1:0] timer_inc;
   logic          expire;      // Last cycle of the window

   assign rise      = sync_b & ~sync_prev;
   assign timer_inc = timer + 1'b1;
   assign expire    = timer_inc >= window;  // Also catches a window shrunk mid-count

   // Two-flop synchronizer plus edge detect flop
   always_ff @(posedge clk_160)
   begin
      if (reset)
      begin
         sync_a    <= '0;
         sync_b    <= '0;
         sync_prev <= '0;
      end
      else
      begin
         sync_a    <= test_clk;
         sync_b    <= sync_a;
         sync_prev <= sync_b;
      end
   end

   // Window timer, wraps every window cycles
   always_ff @(posedge clk_160)
   begin
      if (reset || expire)
      begin
         timer <= '0;
      end
      else
      begin
         timer <= timer_inc;
      end
   end

   // Edge counters, latched and cleared at window end
   always_ff @(posedge clk_160)
   begin
      for (int k = 0; k < N; k++)
      begin
         if (reset)
         begin
            cnt[k]    <= '0;
            counts[k] <= '0;
         end
         else if (expire)
         begin
            counts[k] <= cnt[k] + CW'(rise[k]);  // Include an edge on the last cycle
            cnt[k]    <= '0;
         end
         else
         begin
            cnt[k] <= cnt[k] + CW'(rise[k]);
         end
      end
   end

endmodule

//--- verilog/output_router.sv
`include "nimplus_defines.svh"

module output_router
   import nimplus_pkg::*;
(
   input  logic       clk_160,
   input  logic       reset,
   input  route_src_t src,       // Front panel inputs
   input  route_cfg_t route_cfg, // Per-route selection and invert
   output route_dst_t dst        // Registered outputs
);

   localparam int SW        = `SEL_W;
   localparam int SRC_IDX_W = $clog2(`NUM_SOURCES);

   localparam logic [SW-1:0] SEL_END = SW'(`NUM_SOURCES);  // First out-of-range selection

   logic [`NUM_SOURCES-1:0] src_vec;     // Flat source vector
   logic [`NUM_ROUTES-1:0]  route_bits;  // Selected bit per route

   assign src_vec = src;                 // Struct order already matches source index

   // One bit per route from the source vector
   always_comb
   begin
      for (int r = 0; r < `NUM_ROUTES; r++)
      begin
         if (route_cfg[r].selection < SEL_END)
         begin
            route_bits[r] = src_vec[route_cfg[r].selection[SRC_IDX_W-1:0]];
         end
         else
         begin
            route_bits[r] = 1'b0;        // Out of range gives constant zero
         end
         if (r < `NUM_NIM_OUT)
         begin
            route_bits[r] = route_bits[r] ^ route_cfg[r].invert;  // NIM polarity
         end
      end
   end

   // Single output register stage
   always_ff @(posedge clk_160)
   begin
      if (reset)
      begin
         dst <= '0;
      end
      else
      begin
         dst <= route_dst_t'(route_bits);
      end
   end

endmodule

//--- verilog/register_map.sv
`include "nimplus_defines.svh"

module register_map
   import nimplus_pkg::*;
(
   input  logic                clk_160,
   input  logic                reset,
   input  bus_req_t            bus_req,   // Strobe bus request
   output bus_rsp_t            bus_rsp,   // Acks and read data
   input  clk_counts_t         counts,    // Latest monitor counts
   output route_cfg_t          route_cfg, // Mux settings to the router
   output logic [`COUNT_W-1:0] window     // Monitor window length
);

   localparam int AW         = `ADDR_W;
   localparam int DW         = `REG_W;
   localparam int NUM_STORED = `REG_COUNT_BASE;     // Indices 0-30 are writable
   localparam int IDX_W      = $clog2(NUM_STORED);
   localparam int CNT_IDX_W  = $clog2(`NUM_TEST_CLKS);

   localparam logic [AW-1:0] MUX_END  = AW'(`NUM_ROUTES);
   localparam logic [AW-1:0] WIN_ADDR = AW'(`REG_WINDOW);
   localparam logic [AW-1:0] CNT_BASE = AW'(`REG_COUNT_BASE);
   localparam logic [AW-1:0] REG_END  = AW'(`NUM_REGS);

   reg_word_u         regs [NUM_STORED];            // Settings storage
   logic [IDX_W-1:0]  idx;                          // Storage index
   logic [AW-1:0]     cnt_off;                      // Offset into the counts
   mux_param_t        rd_mux;                       // Mux word, padding cleared
   logic [DW-1:0]     rd_data;                      // Readback mux output
   logic              wrack_q;
   logic              rdack_q;
   logic [DW-1:0]     rd_q;

   // Power-up value of each stored word
   function automatic reg_word_u default_word(int i);
      reg_word_u w;
      w.raw = '0;                                   // Mux settings start cleared
      if (i == `REG_WINDOW)
      begin
         w.win.length = `DEFAULT_WINDOW;
      end
      return w;
   endfunction

   assign idx     = bus_req.addr[IDX_W-1:0];
   assign cnt_off = bus_req.addr - CNT_BASE;

   // Settings writes, count indices are dropped
   always_ff @(posedge clk_160)
   begin
      if (reset)
      begin
         for (int i = 0; i < NUM_STORED; i++)
         begin
            regs[i] <= default_word(i);
         end
      end
      else if (bus_req.wren && bus_req.addr < CNT_BASE)
      begin
         regs[idx].raw <= bus_req.data;
      end
   end

   // Readback selection for the current read index
   always_comb
   begin
      rd_mux         = regs[idx].mux;
      rd_mux.padding = '0;                          // Only invert and selection read back
      if (bus_req.addr < MUX_END)
      begin
         rd_data = rd_mux;
      end
      else if (bus_req.addr == WIN_ADDR)
      begin
         rd_data = DW'(window);
      end
      else if (bus_req.addr >= CNT_BASE && bus_req.addr < REG_END)
      begin
         rd_data = DW'(counts[cnt_off[CNT_IDX_W-1:0]]);  // Zero extended count
      end
      else
      begin
         rd_data = '0;                              // Unmapped index
      end
   end

   // Acks follow their strobe by one cycle
   always_ff @(posedge clk_160)
   begin
      if (reset)
      begin
         wrack_q <= 1'b0;
         rdack_q <= 1'b0;
      end
      else
      begin
         wrack_q <= bus_req.wren;                   // Also for ignored writes
         rdack_q <= bus_req.rden;
      end
   end

   // Read data captured on each strobe, so back-to-back reads pipeline
   always_ff @(posedge clk_160)
   begin
      if (bus_req.rden)
      begin
         rd_q <= rd_data;
      end
   end

   assign bus_rsp = '{wrack: wrack_q, rdack: rdack_q, data: rd_q};

   // Same storage read as route settings and as the window
   always_comb
   begin
      for (int r = 0; r < `NUM_ROUTES; r++)
      begin
         route_cfg[r] = regs[r].mux;
      end
   end

   assign window = regs[`REG_WINDOW].win.length;

endmodule

//--- verilog/nimplus_pkg.sv
`include "nimplus_defines.svh"

package nimplus_pkg;

   // Output mux setting, one per routed output
   typedef struct packed {
      logic [`REG_W-`SEL_W-2:0] padding;
      logic                     invert;     // Used on NIM outputs only
      logic [`SEL_W-1:0]        selection;  // Source index
   } mux_param_t;

   // Clock monitor window setting
   typedef struct packed {
      logic [`REG_W-`COUNT_W-1:0] padding;
      logic [`COUNT_W-1:0]        length;   // In clk_160 cycles
   } window_param_t;

   // Stored word, meaning depends on its index
   typedef union packed {
      logic [`REG_W-1:0] raw;
      mux_param_t        mux;              // Indices 0-29
      window_param_t     win;              // Index 30
   } reg_word_u;

   // Strobe bus from the Ethernet side
   typedef struct packed {
      logic               wren;             // One-cycle write strobe
      logic               rden;             // One-cycle read strobe
      logic [`ADDR_W-1:0] addr;             // Register index
      logic [`REG_W-1:0]  data;             // Write data
   } bus_req_t;

   typedef struct packed {
      logic              wrack;             // One cycle after wren
      logic              rdack;             // One cycle after rden
      logic [`REG_W-1:0] data;              // Valid with rdack
   } bus_rsp_t;

   // Front panel inputs, LSB first flattening gives the source index
   typedef struct packed {
      logic [1:0] sma_in;                   // Sources 28-29
      logic [7:0] rj45_in_2;                // Sources 20-27
      logic [7:0] rj45_in_1;                // Sources 12-19
      logic [3:0] lvds_in;                  // Sources 8-11
      logic [7:0] nim_in;                   // Sources 0-7
   } route_src_t;

   // Routed outputs, bit i is route i
   typedef struct packed {
      logic [1:0]  sma_out;                 // Routes 28-29
      logic [11:0] rj45_out_2;              // Routes 16-27
      logic [11:0] rj45_out_1;              // Routes 4-15
      logic [3:0]  nim_out;                 // Routes 0-3
   } route_dst_t;

   typedef mux_param_t [`NUM_ROUTES-1:0] route_cfg_t;
   typedef logic [`NUM_TEST_CLKS-1:0][`COUNT_W-1:0] clk_counts_t;

endpackage

//--- include/nimplus_defines.svh
`ifndef NIMPLUS_DEFINES_SVH
`define NIMPLUS_DEFINES_SVH

// Router dimensions
`define NUM_SOURCES     30  // 8 NIM, 4 LVDS, 8+8 RJ45, 2 SMA
`define SEL_W           8   // Selection field, 30 and up select zero
`define NUM_ROUTES      30  // 4 NIM, 12+12 RJ45, 2 SMA
`define NUM_NIM_OUT     4   // Routes 0-3 drive the NIM outputs, invertible

// Clock rate monitor
`define NUM_TEST_CLKS   4
`define COUNT_W         32
`define DEFAULT_WINDOW  320 // clk_160 cycles, 2 us

// Register bus
`define REG_W           64
`define ADDR_W          8

// Register indices
`define REG_WINDOW      30  // Monitor window length
`define REG_COUNT_BASE  31  // Read-only counts 31-34
`define NUM_REGS        35

`endif
